// File: tb.f
+incdir+bench
hdl/mm_cfg_pkg.sv
hdl/mm_data_pkg.sv
hdl/tile_bram.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
hdl/tile_sequencer.sv
hdl/matmul_top.sv
bench/matmul_tb.sv

// File: bench/matmul_model.svh
// Reference model and compare tasks for the matrix multiplier testbench
// Included inside matmul_tb, uses its matrices and its abort task

`ifndef MATMUL_MODEL_SVH
`define MATMUL_MODEL_SVH

logic [31:0] rng_state = 32'd60302;   // Fixed seed

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Small signed value, about +-2.0 in Q8.8
function automatic elem_t small_elem();
    logic [31:0]       r;
    logic signed [9:0] v;
    r = next_rand();
    v = r[9:0];
    return v;   // Sign extends
endfunction

// Drop the fraction bits, then clamp to one element
function automatic elem_t rescale(input longint sum);
    longint s;
    s = sum >>> FRAC_WIDTH;
    if (s > ELEM_MAX) begin
        return elem_t'(ELEM_MAX);
    end else if (s < ELEM_MIN) begin
        return elem_t'(ELEM_MIN);
    end
    return elem_t'(s);
endfunction

// Full C = A * B from the host copies
task automatic compute_model();
    longint sum;
    for (int i = 0; i < A_ROWS; i++) begin
        for (int j = 0; j < B_COLS; j++) begin
            sum = 0;
            for (int k = 0; k < INNER_DIM; k++) begin
                sum += longint'(mat_a[i][k]) * longint'(mat_b[k][j]);
            end
            mat_c[i][j] = rescale(sum);
        end
    end
endtask

// Row r of tile (tr, tc), lowest column in slot 0
function automatic res_row_t expected_row(input int tr, input int tc, input int r);
    res_row_t e;
    e.tile_row    = TR_WIDTH'(tr);
    e.tile_col    = TC_WIDTH'(tc);
    e.row_in_tile = RIT_WIDTH'(r);
    for (int j = 0; j < BLOCK_SIZE; j++) begin
        e.data[j] = mat_c[tr * BLOCK_SIZE + r][tc * BLOCK_SIZE + j];
    end
    return e;
endfunction

task automatic check_row(input string name, input res_row_t expected, input res_row_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("error %s: expected %h actual %h", name, expected, actual));
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("error %s: expected %b actual %b", name, expected, actual));
    end
endtask

`endif

// File: bench/matmul_tb.sv
// Testbench for the block matrix multiplier
// Loads A and B over the load port, runs the product, checks every row against a model

`timescale 1ns/10ps

module matmul_tb
    import mm_cfg_pkg::*, mm_data_pkg::*;
();

    localparam int WAIT_LIMIT = 200;   // Cycles allowed per handshake wait

    logic     clk;
    logic     rst_n;
    logic     ld_req;
    ld_cmd_t  ld_cmd;
    logic     ld_ack;
    logic     run_req;
    logic     run_ack;
    logic     res_req;
    logic     res_ack;
    res_row_t res;

    // Host copies of the operands and the expected product
    elem_t mat_a [A_ROWS][INNER_DIM];
    elem_t mat_b [INNER_DIM][B_COLS];
    elem_t mat_c [A_ROWS][B_COLS];

    matmul_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .ld_req  (ld_req),
        .ld_cmd  (ld_cmd),
        .ld_ack  (ld_ack),
        .run_req (run_req),
        .run_ack (run_ack),
        .res_req (res_req),
        .res_ack (res_ack),
        .res     (res)
    );

    always #50 clk = ~clk;   // 100 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    `include "matmul_model.svh"

    // Handshake waits, all sampled on the falling edge
    task automatic wait_ld_ack(input logic level, input string what);
        int n;
        n = 0;
        while (ld_ack !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run($sformatf("ld_ack never went %b in %s", level, what));
        end
    endtask

    task automatic wait_res_req(input logic level, input string what);
        int n;
        n = 0;
        while (res_req !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run($sformatf("res_req never went %b in %s", level, what));
        end
    endtask

    task automatic wait_run_ack(input logic level, input string what);
        int n;
        n = 0;
        while (run_ack !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run($sformatf("run_ack never went %b in %s", level, what));
        end
    endtask

    // One four-phase load, ack expected on the very next edge
    task automatic load_word(input logic sel, input logic [ADDR_WIDTH-1:0] addr,
                             input block_t data);
        check_bit("load idle ack", 1'b0, ld_ack);
        ld_cmd.mat_sel = sel;
        ld_cmd.addr    = addr;
        ld_cmd.data    = data;
        ld_req         = 1'b1;
        @(negedge clk);
        check_bit("load ack latency", 1'b1, ld_ack);
        ld_req = 1'b0;
        wait_ld_ack(1'b0, "load release");
    endtask

    // A word r*INNER_DIM+k holds column k of tile row r
    task automatic load_a();
        block_t w;
        for (int r = 0; r < TILE_ROWS; r++) begin
            for (int k = 0; k < INNER_DIM; k++) begin
                for (int i = 0; i < BLOCK_SIZE; i++) w[i] = mat_a[r * BLOCK_SIZE + i][k];
                load_word(1'b0, ADDR_WIDTH'(r * INNER_DIM + k), w);
            end
        end
    endtask

    // B word c*INNER_DIM+k holds row k of tile column c
    task automatic load_b();
        block_t w;
        for (int c = 0; c < TILE_COLS; c++) begin
            for (int k = 0; k < INNER_DIM; k++) begin
                for (int j = 0; j < BLOCK_SIZE; j++) w[j] = mat_b[k][c * BLOCK_SIZE + j];
                load_word(1'b1, ADDR_WIDTH'(c * INNER_DIM + k), w);
            end
        end
    endtask

    task automatic fill_a_random();
        for (int i = 0; i < A_ROWS; i++)
            for (int k = 0; k < INNER_DIM; k++) mat_a[i][k] = small_elem();
    endtask

    task automatic fill_b_random();
        for (int k = 0; k < INNER_DIM; k++)
            for (int j = 0; j < B_COLS; j++) mat_b[k][j] = small_elem();
    endtask

    // +-64.0 times +-16.0 summed four times, far past the element range
    task automatic fill_overflow();
        for (int i = 0; i < A_ROWS; i++)
            for (int k = 0; k < INNER_DIM; k++)
                mat_a[i][k] = (i % 2 == 0) ? 16'sh4000 : 16'shC000;
        for (int k = 0; k < INNER_DIM; k++)
            for (int j = 0; j < B_COLS; j++)
                mat_b[k][j] = (j % 2 == 0) ? 16'sh1000 : 16'shF000;
    endtask

    // Full run, collecting all rows with up to max_delay cycles of back-pressure
    task automatic run_and_check(input string name, input int max_delay);
        string    row_name;
        res_row_t held;
        int       delay;
        run_req = 1'b1;
        for (int tr = 0; tr < TILE_ROWS; tr++) begin
            for (int tc = 0; tc < TILE_COLS; tc++) begin
                for (int r = 0; r < BLOCK_SIZE; r++) begin
                    row_name = $sformatf("%s row %0d.%0d.%0d", name, tr, tc, r);
                    wait_res_req(1'b1, "result row");
                    check_bit({row_name, " run_ack early"}, 1'b0, run_ack);
                    check_row(row_name, expected_row(tr, tc, r), res);
                    held  = res;
                    delay = int'(next_rand() % (max_delay + 1));
                    repeat (delay) begin   // Row must sit still while unacked
                        @(negedge clk);
                        check_bit({row_name, " res_req held"}, 1'b1, res_req);
                        check_row({row_name, " hold"}, held, res);
                    end
                    res_ack = 1'b1;
                    wait_res_req(1'b0, "result release");
                    res_ack = 1'b0;
                end
            end
        end
        wait_run_ack(1'b1, "run completion");
        repeat (2) begin   // Held while run_req stays up
            @(negedge clk);
            check_bit({name, " run_ack held"}, 1'b1, run_ack);
        end
        run_req = 1'b0;
        @(negedge clk);
        check_bit({name, " run_ack fall"}, 1'b0, run_ack);
        check_bit({name, " res_req idle"}, 1'b0, res_req);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        ld_req  = 1'b0;
        ld_cmd  = '0;
        run_req = 1'b0;
        res_ack = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Idle outputs after reset
        check_bit("reset ld_ack", 1'b0, ld_ack);
        check_bit("reset run_ack", 1'b0, run_ack);
        check_bit("reset res_req", 1'b0, res_req);

        // Small random operands, host takes rows at once
        fill_a_random();
        fill_b_random();
        load_a();
        load_b();
        compute_model();
        run_and_check("random", 0);

        // Every C element clamps to max or min
        fill_overflow();
        load_a();
        load_b();
        compute_model();
        run_and_check("saturate", 0);

        fill_a_random();
        fill_b_random();
        load_a();
        load_b();
        compute_model();
        run_and_check("backpressure", 3);

        // New weights only, A stays in memory
        fill_b_random();
        load_b();
        compute_model();
        run_and_check("reuse_a", 3);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: hdl/matmul_top.sv
// Top level of the block matrix multiplier
// Host sees the load, run and result handshakes of the sequencer

`timescale 1ns/10ps

module matmul_top
    import mm_cfg_pkg::*, mm_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld_req,
    input  ld_cmd_t  ld_cmd,
    output logic     ld_ack,
    input  logic     run_req,
    output logic     run_ack,
    output logic     res_req,
    input  logic     res_ack,
    output res_row_t res
);

    logic                    a_we;
    logic                    b_we;
    logic [ADDR_WIDTH-1:0]   wr_addr;
    block_t                  wr_data;
    logic                    rd_en;
    logic [ADDR_WIDTH-1:0]   a_raddr;
    logic [ADDR_WIDTH-1:0]   b_raddr;
    block_t                  a_rdata;    // West edge of the array
    block_t                  b_rdata;    // North edge of the array
    logic                    feed_valid;
    logic                    clear_acc;
    block_t [BLOCK_SIZE-1:0] c_rows;

    tile_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_req     (ld_req),
        .ld_cmd     (ld_cmd),
        .ld_ack     (ld_ack),
        .a_we       (a_we),
        .b_we       (b_we),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .a_raddr    (a_raddr),
        .b_raddr    (b_raddr),
        .feed_valid (feed_valid),
        .clear_acc  (clear_acc),
        .c_rows     (c_rows),
        .run_req    (run_req),
        .run_ack    (run_ack),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .res        (res)
    );

    // Stationary input
    tile_bram #(.DEPTH(MEM_DEPTH)) mem_a (
        .clk   (clk),
        .we    (a_we),
        .waddr (wr_addr),
        .wdata (wr_data),
        .re    (rd_en),
        .raddr (a_raddr),
        .rdata (a_rdata)
    );

    // Weights
    tile_bram #(.DEPTH(MEM_DEPTH)) mem_b (
        .clk   (clk),
        .we    (b_we),
        .waddr (wr_addr),
        .wdata (wr_data),
        .re    (rd_en),
        .raddr (b_raddr),
        .rdata (b_rdata)
    );

    systolic_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_acc  (clear_acc),
        .feed_valid (feed_valid),
        .west       (a_rdata),
        .north      (b_rdata),
        .c_rows     (c_rows)
    );

endmodule

// File: hdl/tile_sequencer.sv
// Control for load, run and result handshakes of the block multiplier
// Walks C tile by tile, feeds the array from both memories, drains the rows

`timescale 1ns/10ps

module tile_sequencer
    import mm_cfg_pkg::*, mm_data_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ld_req,
    input  ld_cmd_t                 ld_cmd,
    output logic                    ld_ack,
    output logic                    a_we,
    output logic                    b_we,
    output logic [ADDR_WIDTH-1:0]   wr_addr,
    output block_t                  wr_data,
    output logic                    rd_en,       // Shared by both memories
    output logic [ADDR_WIDTH-1:0]   a_raddr,
    output logic [ADDR_WIDTH-1:0]   b_raddr,
    output logic                    feed_valid,
    output logic                    clear_acc,
    input  block_t [BLOCK_SIZE-1:0] c_rows,
    input  logic                    run_req,
    output logic                    run_ack,
    output logic                    res_req,
    input  logic                    res_ack,
    output res_row_t                res
);

    typedef enum logic [2:0] {
        S_IDLE, S_CLEAR, S_STREAM, S_DRAIN, S_OUTPUT, S_DONE
    } state_t;

    state_t                 state;
    logic [K_WIDTH-1:0]     k_cnt;       // Inner index being read
    logic [DRAIN_WIDTH-1:0] drain_cnt;
    logic [TR_WIDTH-1:0]    tile_row;
    logic [TC_WIDTH-1:0]    tile_col;
    logic [RIT_WIDTH-1:0]   row_in_tile;
    logic                   ld_fire;
    logic                   res_show;    // Present the next row
    logic                   res_take;    // Host took the current row
    logic                   last_row;
    logic                   last_tile;

    // Load write lands on the edge that raises ld_ack
    assign ld_fire = ld_req && !ld_ack && (state == S_IDLE);
    assign a_we    = ld_fire && !ld_cmd.mat_sel;
    assign b_we    = ld_fire && ld_cmd.mat_sel;
    assign wr_addr = ld_cmd.addr;
    assign wr_data = ld_cmd.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_ack <= 1'b0;
        end else if (ld_fire) begin
            ld_ack <= 1'b1;
        end else if (!ld_req) begin
            ld_ack <= 1'b0;   // Close the four-phase cycle
        end
    end

    // A word per tile row and k, B word per tile column and k
    assign rd_en     = (state == S_STREAM);
    assign a_raddr   = ADDR_WIDTH'(tile_row * INNER_DIM + k_cnt);
    assign b_raddr   = ADDR_WIDTH'(tile_col * INNER_DIM + k_cnt);
    assign clear_acc = (state == S_CLEAR);

    // Memory data shows up one cycle after the read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feed_valid <= 1'b0;
        end else begin
            feed_valid <= rd_en;
        end
    end

    assign res_show  = (state == S_OUTPUT) && !res_req && !res_ack;
    assign res_take  = res_req && res_ack;
    assign last_row  = (row_in_tile == RIT_WIDTH'(BLOCK_SIZE - 1));
    assign last_tile = (tile_row == TR_WIDTH'(TILE_ROWS - 1))
                    && (tile_col == TC_WIDTH'(TILE_COLS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            k_cnt       <= '0;
            drain_cnt   <= '0;
            tile_row    <= '0;
            tile_col    <= '0;
            row_in_tile <= '0;
            res_req     <= 1'b0;
            run_ack     <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    tile_row <= '0;
                    tile_col <= '0;
                    if (run_req) state <= S_CLEAR;
                end
                S_CLEAR: begin   // One cycle of accumulator clear
                    k_cnt <= '0;
                    state <= S_STREAM;
                end
                S_STREAM: begin
                    k_cnt <= k_cnt + 1'b1;
                    if (k_cnt == K_WIDTH'(INNER_DIM - 1)) begin
                        drain_cnt <= '0;
                        state     <= S_DRAIN;
                    end
                end
                S_DRAIN: begin   // Wait for the corner cell
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_WIDTH'(DRAIN_CYCLES - 1)) begin
                        row_in_tile <= '0;
                        state       <= S_OUTPUT;
                    end
                end
                S_OUTPUT: begin   // Array holds its sums until all rows are taken
                    if (res_show) begin
                        res_req <= 1'b1;
                    end else if (res_take) begin
                        res_req     <= 1'b0;
                        row_in_tile <= row_in_tile + 1'b1;
                        if (last_row && last_tile) begin
                            run_ack <= 1'b1;
                            state   <= S_DONE;
                        end else if (last_row) begin
                            if (tile_col == TC_WIDTH'(TILE_COLS - 1)) begin
                                tile_col <= '0;
                                tile_row <= tile_row + 1'b1;
                            end else begin
                                tile_col <= tile_col + 1'b1;
                            end
                            state <= S_CLEAR;
                        end
                    end
                end
                S_DONE: begin
                    if (!run_req) begin
                        run_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Row payload captured as res_req rises
    always_ff @(posedge clk) begin
        if (res_show) begin
            res.tile_row    <= tile_row;
            res.tile_col    <= tile_col;
            res.row_in_tile <= row_in_tile;
            res.data        <= c_rows[row_in_tile];
        end
    end

    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (res_req && !res_ack) |=> $stable(res))
        else $error("tile_sequencer: res changed while waiting for res_ack");

    a_ld_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ld_req) |-> (state == S_IDLE))
        else $error("tile_sequencer: load request during a run");

endmodule

// File: hdl/systolic_array.sv
// Square grid of mac_pe cells with skew registers on the west and north edges
// Row i of c_rows carries the results of cells (i, 0..BLOCK_SIZE-1)

`timescale 1ns/10ps

module systolic_array
    import mm_cfg_pkg::*, mm_data_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear_acc,
    input  logic                    feed_valid,   // Aligned with west and north
    input  block_t                  west,         // A column slice
    input  block_t                  north,        // B row slice
    output block_t [BLOCK_SIZE-1:0] c_rows
);

    // Delayed copies of the edge words
    // Entry d is d+1 cycles old
    block_t                  west_q  [BLOCK_SIZE-1];
    block_t                  north_q [BLOCK_SIZE-1];
    logic [BLOCK_SIZE-2:0]   valid_q;

    // Grid links with index BLOCK_SIZE at the far edge
    elem_t a_h [BLOCK_SIZE][BLOCK_SIZE+1];   // Runs east
    logic  v_h [BLOCK_SIZE][BLOCK_SIZE+1];   // Runs east with a
    elem_t b_v [BLOCK_SIZE+1][BLOCK_SIZE];   // Runs south
    elem_t res_g [BLOCK_SIZE][BLOCK_SIZE];

    always_ff @(posedge clk) begin
        west_q[0]  <= west;
        north_q[0] <= north;
        for (int d = 1; d < BLOCK_SIZE - 1; d++) begin
            west_q[d]  <= west_q[d-1];
            north_q[d] <= north_q[d-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= feed_valid;
            for (int d = 1; d < BLOCK_SIZE - 1; d++) begin
                valid_q[d] <= valid_q[d-1];
            end
        end
    end

    // Lane i enters i cycles late so equal k values meet in every cell
    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_edge
        if (i == 0) begin : g_direct
            assign a_h[0][0] = west[0];
            assign v_h[0][0] = feed_valid;
            assign b_v[0][0] = north[0];
        end else begin : g_skew
            assign a_h[i][0] = west_q[i-1][i];
            assign v_h[i][0] = valid_q[i-1];
            assign b_v[0][i] = north_q[i-1][i];
        end
    end

    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_row
        for (genvar j = 0; j < BLOCK_SIZE; j++) begin : g_col
            mac_pe u_pe (
                .clk    (clk),
                .rst_n  (rst_n),
                .clear  (clear_acc),
                .a_in   (a_h[i][j]),
                .b_in   (b_v[i][j]),
                .v_in   (v_h[i][j]),
                .a_out  (a_h[i][j+1]),
                .b_out  (b_v[i+1][j]),
                .v_out  (v_h[i][j+1]),
                .result (res_g[i][j])
            );
        end
    end

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            for (int j = 0; j < BLOCK_SIZE; j++) begin
                c_rows[i][j] = res_g[i][j];
            end
        end
    end

endmodule

// File: hdl/mac_pe.sv
// One output-stationary multiply-accumulate cell of the systolic array
// Passes operands east and south, keeps its own sum, shows it rescaled

`timescale 1ns/10ps

module mac_pe
    import mm_cfg_pkg::*, mm_data_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,    // Start of a new tile
    input  elem_t a_in,     // From the west
    input  elem_t b_in,     // From the north
    input  logic  v_in,
    output elem_t a_out,    // To the east
    output elem_t b_out,    // To the south
    output logic  v_out,
    output elem_t result
);

    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] prod;
    logic signed [ACC_WIDTH-1:0] scaled;

    assign prod = a_in * b_in;   // Signed 16x16, kept at 32 bits

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (v_in) begin
            acc <= acc + prod;   // Q16.16 running sum
        end
    end

    // Operand pipeline toward the neighbours
    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_out <= 1'b0;
        end else begin
            v_out <= v_in;
        end
    end

    // Back to Q8.8 then clamp
    assign scaled = acc >>> FRAC_WIDTH;

    always_comb begin
        if (scaled > ELEM_MAX) begin
            result = elem_t'(ELEM_MAX);
        end else if (scaled < ELEM_MIN) begin
            result = elem_t'(ELEM_MIN);
        end else begin
            result = scaled[DATA_WIDTH-1:0];
        end
    end

    // Sequencer keeps a clear cycle apart from every operand beat
    a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n) !(clear && v_in))
        else $error("mac_pe: clear and v_in high together");

endmodule

// File: hdl/tile_bram.sv
// Simple dual-port memory holding block words of A or B
// Synchronous write, registered read with one cycle of latency

`timescale 1ns/10ps

module tile_bram
    import mm_cfg_pkg::*, mm_data_pkg::*;
#(
    parameter int DEPTH = MEM_DEPTH
) (
    input  logic                  clk,
    // Write port from the load handshake
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  block_t                wdata,
    // Read port from the sequencer
    input  logic                  re,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output block_t                rdata
);

    block_t mem [DEPTH];   // Plain inferred storage

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Data appears the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // Host addresses must fit the instance depth
    a_waddr_range: assert property (@(posedge clk) we |-> (waddr < DEPTH))
        else $error("tile_bram: write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

// File: hdl/mm_data_pkg.sv
// Data types passed between host, memories, array and sequencer
// Shared by the RTL and the testbench

package mm_data_pkg;

    import mm_cfg_pkg::*;

    // One signed Q8.8 element
    typedef logic signed [DATA_WIDTH-1:0] elem_t;

    // Memory word
    // A holds a column slice of a tile, B a row slice
    // Element i sits in slot i
    typedef elem_t [BLOCK_SIZE-1:0] block_t;

    // Host load command
    typedef struct packed {
        logic                  mat_sel;   // 0 selects A, 1 selects B
        logic [ADDR_WIDTH-1:0] addr;
        block_t                data;
    } ld_cmd_t;

    // One finished row of a C tile
    typedef struct packed {
        logic [TR_WIDTH-1:0]  tile_row;
        logic [TC_WIDTH-1:0]  tile_col;
        logic [RIT_WIDTH-1:0] row_in_tile;
        block_t               data;          // Lowest column in slot 0
    } res_row_t;

endpackage

// File: hdl/mm_cfg_pkg.sv
// Configuration constants for the block matrix multiplier
// Imported by every RTL block that needs sizes, formats or counter widths

package mm_cfg_pkg;

    // Signed Q8.8 elements
    localparam int DATA_WIDTH = 16;
    localparam int FRAC_WIDTH = 8;     // Fraction bits dropped after accumulation
    localparam int ACC_WIDTH  = 32;    // Full product width

    // Saturation bounds of one element
    localparam int ELEM_MAX = (1 << (DATA_WIDTH - 1)) - 1;
    localparam int ELEM_MIN = -(1 << (DATA_WIDTH - 1));

    // Matrix geometry
    localparam int BLOCK_SIZE = 2;     // Array side and tile side
    localparam int INNER_DIM  = 4;     // Columns of A, rows of B
    localparam int A_ROWS     = 4;
    localparam int B_COLS     = 4;

    localparam int TILE_ROWS = A_ROWS / BLOCK_SIZE;
    localparam int TILE_COLS = B_COLS / BLOCK_SIZE;

    // One block word per tile index and k
    localparam int MEM_DEPTH  = TILE_ROWS * INNER_DIM;
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

    // Memory read latency plus skew to the far corner cell
    localparam int DRAIN_CYCLES = 2 * BLOCK_SIZE - 1;

    // Sequencer counter widths
    localparam int K_WIDTH     = $clog2(INNER_DIM);
    localparam int DRAIN_WIDTH = $clog2(DRAIN_CYCLES + 1);
    localparam int TR_WIDTH    = $clog2(TILE_ROWS);
    localparam int TC_WIDTH    = $clog2(TILE_COLS);
    localparam int RIT_WIDTH   = $clog2(BLOCK_SIZE);

endpackage
